//--- verilog/transmissao_serial_pkg.sv
`default_nettype none

package transmissao_serial_pkg;

    // temporizacao do bit serial
    localparam int CICLOS_POR_BIT = 4;
    localparam int LARGURA_TEMPO  = $clog2(CICLOS_POR_BIT);

    // quadro: partida + 8 dados + parada
    localparam int BITS_QUADRO    = 10;
    localparam int LARGURA_COLUNA = $clog2(BITS_QUADRO);

    // codigo do estado vai direto para o display
    typedef enum logic [3:0] {
        inicial       = 4'd0,
        preparacao    = 4'd1,
        carga_linha   = 4'd2,
        transmissao   = 4'd3,
        proximo_bit   = 4'd4,
        proxima_linha = 4'd5,
        finalizacao   = 4'd6
    } estado_t;

endpackage

`default_nettype wire

//--- verilog/tabuleiro_pkg.sv
`default_nettype none

package tabuleiro_pkg;

    // dimensoes do tabuleiro
    localparam int NUM_LINHAS    = 8;
    localparam int NUM_COLUNAS   = 8;
    localparam int LARGURA_LINHA = $clog2(NUM_LINHAS);

    // mapa apb: linha n no endereco 4*n
    localparam int ENDERECO_LARGURA = 5;
    localparam int ENDERECO_MAXIMO  = 4 * (NUM_LINHAS - 1);

    typedef enum logic {
        leitura = 1'b0,
        escrita = 1'b1
    } apb_op_t;

endpackage

`default_nettype wire

//--- verilog/tabuleiro_apb.sv
`default_nettype none

module tabuleiro_apb (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [tabuleiro_pkg::ENDERECO_LARGURA-1:0] paddr,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   pwdata,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_0,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_1,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_2,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_3,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_4,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_5,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_6,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]   linha_7
);

    import tabuleiro_pkg::*;

    logic [NUM_COLUNAS-1:0]   tabuleiro [NUM_LINHAS];
    logic [LARGURA_LINHA-1:0] indice;
    logic                     endereco_valido;
    logic                     acesso;
    apb_op_t                  operacao;

    assign operacao = pwrite ? escrita : leitura;
    assign acesso   = psel && penable;

    // so enderecos alinhados dentro do mapa
    assign endereco_valido = (paddr[1:0] == 2'b00) &&
                             (paddr <= ENDERECO_LARGURA'(ENDERECO_MAXIMO));
    assign indice          = paddr[LARGURA_LINHA+1:2];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LINHAS; i++) begin
                tabuleiro[i] <= '0;
            end
        end else if (acesso && operacao == escrita && endereco_valido) begin
            tabuleiro[indice] <= pwdata;
        end
    end

    // leitura combinacional na fase de acesso
    always_comb begin
        prdata = '0;
        if (acesso && operacao == leitura && endereco_valido) begin
            prdata = tabuleiro[indice];
        end
    end

    // sem estados de espera
    assign pready  = 1'b1;
    assign pslverr = acesso && !endereco_valido;

    assign linha_0 = tabuleiro[0];
    assign linha_1 = tabuleiro[1];
    assign linha_2 = tabuleiro[2];
    assign linha_3 = tabuleiro[3];
    assign linha_4 = tabuleiro[4];
    assign linha_5 = tabuleiro[5];
    assign linha_6 = tabuleiro[6];
    assign linha_7 = tabuleiro[7];

    // protocolo do mestre: penable so dentro de uma selecao
    a_penable_com_psel: assert property (
        @(posedge clock) disable iff (!rst_n)
        penable |-> psel
    );

endmodule

`default_nettype wire

//--- verilog/transmissao_serial_fd.sv
`default_nettype none

module transmissao_serial_fd (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_0,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_1,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_2,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_3,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_4,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_5,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_6,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0] linha_7,
    input  logic                                  zera_linha,
    input  logic                                  zera_coluna,
    input  logic                                  carrega_linha,
    input  logic                                  partida_serial,
    input  logic                                  conta_coluna,
    input  logic                                  conta_linha,
    output logic                                  fim_bit,
    output logic                                  fim_coluna,
    output logic                                  fim_linha,
    output logic                                  saida_serial
);

    import transmissao_serial_pkg::*;
    import tabuleiro_pkg::*;

    logic [LARGURA_TEMPO-1:0]  contador_bit;
    logic [LARGURA_COLUNA-1:0] coluna;
    logic [LARGURA_LINHA-1:0]  linha;
    logic [BITS_QUADRO-1:0]    quadro;
    logic [NUM_COLUNAS-1:0]    tabuleiro [NUM_LINHAS];
    logic [NUM_COLUNAS-1:0]    linha_atual;

    // temporizador do bit
    // a janela de cada bit e 1..CICLOS-1 e depois 0, o zero cai em proximo_bit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            contador_bit <= '0;
        end else if (partida_serial) begin
            contador_bit <= LARGURA_TEMPO'(1);
        end else if (contador_bit == LARGURA_TEMPO'(CICLOS_POR_BIT - 1)) begin
            contador_bit <= '0;
        end else begin
            contador_bit <= contador_bit + 1'b1;
        end
    end

    assign fim_bit = (contador_bit == LARGURA_TEMPO'(CICLOS_POR_BIT - 1));

    // contador de coluna, modulo BITS_QUADRO
    always_ff @(posedge clock) begin
        if (!rst_n || zera_coluna) begin
            coluna <= '0;
        end else if (conta_coluna) begin
            if (fim_coluna) begin
                coluna <= '0;
            end else begin
                coluna <= coluna + 1'b1;
            end
        end
    end

    assign fim_coluna = (coluna == LARGURA_COLUNA'(BITS_QUADRO - 1));

    // contador de linha
    always_ff @(posedge clock) begin
        if (!rst_n || zera_linha) begin
            linha <= '0;
        end else if (conta_linha) begin
            linha <= linha + 1'b1;
        end
    end

    assign fim_linha = (linha == LARGURA_LINHA'(NUM_LINHAS - 1));

    // selecao da linha a carregar
    assign tabuleiro = '{linha_0, linha_1, linha_2, linha_3,
                         linha_4, linha_5, linha_6, linha_7};
    assign linha_atual = tabuleiro[linha];

    // registrador de deslocamento do quadro, lsb sai primeiro
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            quadro <= '1;
        end else if (carrega_linha) begin
            quadro <= {1'b1, linha_atual, 1'b0};
        end else if (conta_coluna) begin
            quadro <= {1'b1, quadro[BITS_QUADRO-1:1]};
        end
    end

    assign saida_serial = quadro[0];

    a_coluna_limite: assert property (
        @(posedge clock) disable iff (!rst_n)
        coluna <= LARGURA_COLUNA'(BITS_QUADRO - 1)
    );

endmodule

`default_nettype wire

//--- verilog/transmissao_serial_uc.sv
`default_nettype none

module transmissao_serial_uc (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            iniciar,
    input  logic                            fim_bit,
    input  logic                            fim_coluna,
    input  logic                            fim_linha,
    output logic                            zera_linha,
    output logic                            zera_coluna,
    output logic                            carrega_linha,
    output logic                            partida_serial,
    output logic                            conta_coluna,
    output logic                            conta_linha,
    output logic                            fim,
    output transmissao_serial_pkg::estado_t db_estado
);

    import transmissao_serial_pkg::*;

    estado_t estado;
    estado_t proximo;

    // registrador de estado
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            estado <= inicial;
        end else begin
            estado <= proximo;
        end
    end

    // logica de proximo estado
    always_comb begin
        proximo = estado;
        case (estado)
            inicial: begin
                // iniciar so e visto aqui
                if (iniciar) begin
                    proximo = preparacao;
                end
            end
            preparacao: begin
                proximo = carga_linha;
            end
            carga_linha: begin
                proximo = transmissao;
            end
            transmissao: begin
                if (fim_bit) begin
                    proximo = proximo_bit;
                end
            end
            proximo_bit: begin
                if (!fim_coluna) begin
                    proximo = transmissao;
                end else if (fim_linha) begin
                    proximo = finalizacao;
                end else begin
                    proximo = proxima_linha;
                end
            end
            proxima_linha: begin
                proximo = carga_linha;
            end
            finalizacao: begin
                proximo = inicial;
            end
            default: begin
                proximo = inicial;
            end
        endcase
    end

    // saidas de moore
    always_comb begin
        zera_linha     = 1'b0;
        zera_coluna    = 1'b0;
        carrega_linha  = 1'b0;
        partida_serial = 1'b0;
        conta_coluna   = 1'b0;
        conta_linha    = 1'b0;
        fim            = 1'b0;
        case (estado)
            preparacao: begin
                zera_linha  = 1'b1;
                zera_coluna = 1'b1;
            end
            carga_linha: begin
                zera_coluna    = 1'b1;
                carrega_linha  = 1'b1;
                partida_serial = 1'b1;
            end
            proximo_bit:   conta_coluna = 1'b1;
            proxima_linha: conta_linha  = 1'b1;
            finalizacao:   fim          = 1'b1;
            default: begin
            end
        endcase
    end

    assign db_estado = estado;

    // fim volta a zero no ciclo seguinte
    a_fim_pulso: assert property (
        @(posedge clock) disable iff (!rst_n)
        fim |=> !fim
    );

endmodule

`default_nettype wire

//--- verilog/hexa7seg.sv
`default_nettype none

module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // segmentos gfedcba, ativos em alto
    always_comb begin
        case (hexa)
            4'h0: display = 7'b0111111;
            4'h1: display = 7'b0000110;
            4'h2: display = 7'b1011011;
            4'h3: display = 7'b1001111;
            4'h4: display = 7'b1100110;
            4'h5: display = 7'b1101101;
            4'h6: display = 7'b1111101;
            4'h7: display = 7'b0000111;
            4'h8: display = 7'b1111111;
            4'h9: display = 7'b1101111;
            4'ha: display = 7'b1110111;
            4'hb: display = 7'b1111100;
            4'hc: display = 7'b0111001;
            4'hd: display = 7'b1011110;
            4'he: display = 7'b1111001;
            4'hf: display = 7'b1110001;
            default: display = 7'b0000000;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/transmissao_serial.sv
`default_nettype none

module transmissao_serial (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       iniciar,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [tabuleiro_pkg::ENDERECO_LARGURA-1:0] paddr,
    input  logic [tabuleiro_pkg::NUM_COLUNAS-1:0]      pwdata,
    output logic [tabuleiro_pkg::NUM_COLUNAS-1:0]      prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    output logic                                       saida_serial,
    output logic                                       fim,
    output logic                                       db_partida_serial,
    output logic                                       db_saida_serial,
    output logic [6:0]                                 db_estado
);

    import transmissao_serial_pkg::*;
    import tabuleiro_pkg::*;

    logic [NUM_COLUNAS-1:0] s_linha [NUM_LINHAS];
    logic                   s_zera_linha;
    logic                   s_zera_coluna;
    logic                   s_carrega_linha;
    logic                   s_partida_serial;
    logic                   s_conta_coluna;
    logic                   s_conta_linha;
    logic                   s_fim_bit;
    logic                   s_fim_coluna;
    logic                   s_fim_linha;
    logic                   s_saida_serial;
    estado_t                s_estado;

    // banco de registradores do tabuleiro
    tabuleiro_apb u_tabuleiro_apb (
        .clock   (clock),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .linha_0 (s_linha[0]),
        .linha_1 (s_linha[1]),
        .linha_2 (s_linha[2]),
        .linha_3 (s_linha[3]),
        .linha_4 (s_linha[4]),
        .linha_5 (s_linha[5]),
        .linha_6 (s_linha[6]),
        .linha_7 (s_linha[7])
    );

    // fluxo de dados
    transmissao_serial_fd u_fd (
        .clock          (clock),
        .rst_n          (rst_n),
        .linha_0        (s_linha[0]),
        .linha_1        (s_linha[1]),
        .linha_2        (s_linha[2]),
        .linha_3        (s_linha[3]),
        .linha_4        (s_linha[4]),
        .linha_5        (s_linha[5]),
        .linha_6        (s_linha[6]),
        .linha_7        (s_linha[7]),
        .zera_linha     (s_zera_linha),
        .zera_coluna    (s_zera_coluna),
        .carrega_linha  (s_carrega_linha),
        .partida_serial (s_partida_serial),
        .conta_coluna   (s_conta_coluna),
        .conta_linha    (s_conta_linha),
        .fim_bit        (s_fim_bit),
        .fim_coluna     (s_fim_coluna),
        .fim_linha      (s_fim_linha),
        .saida_serial   (s_saida_serial)
    );

    // unidade de controle
    transmissao_serial_uc u_uc (
        .clock          (clock),
        .rst_n          (rst_n),
        .iniciar        (iniciar),
        .fim_bit        (s_fim_bit),
        .fim_coluna     (s_fim_coluna),
        .fim_linha      (s_fim_linha),
        .zera_linha     (s_zera_linha),
        .zera_coluna    (s_zera_coluna),
        .carrega_linha  (s_carrega_linha),
        .partida_serial (s_partida_serial),
        .conta_coluna   (s_conta_coluna),
        .conta_linha    (s_conta_linha),
        .fim            (fim),
        .db_estado      (s_estado)
    );

    hexa7seg u_hexa_estado (
        .hexa    (s_estado),
        .display (db_estado)
    );

    assign saida_serial = s_saida_serial;

    // depuracao
    assign db_partida_serial = s_partida_serial;
    assign db_saida_serial   = s_saida_serial;

endmodule

`default_nettype wire

//--- testbench/gerador_clock.sv
`default_nettype none

module gerador_clock #(
    parameter int PERIODO = 100
) (
    output logic clock
);

    // meio periodo em cada nivel
    initial begin
        clock = 1'b0;
        forever begin
            #(PERIODO / 2) clock = ~clock;
        end
    end

endmodule

`default_nettype wire

//--- testbench/transmissao_serial_tb.sv
`default_nettype none

module transmissao_serial_tb;

    import transmissao_serial_pkg::*;
    import tabuleiro_pkg::*;

    typedef struct packed {
        apb_op_t                     op;
        logic [ENDERECO_LARGURA-1:0] endereco;
        logic [NUM_COLUNAS-1:0]      dado;
        logic [NUM_COLUNAS-1:0]      esperado;
        logic                        erro;
    } entrada_t;

    localparam int NUM_ENTRADAS = 44;
    localparam int CICLOS_QUADRO = BITS_QUADRO * CICLOS_POR_BIT;
    localparam int CICLOS_TRANSMISSAO = 3 + NUM_LINHAS * (CICLOS_QUADRO + 2) + 2 * CICLOS_QUADRO + 4;
    localparam int LIMITE = 10 + 4 * NUM_ENTRADAS + 2 * CICLOS_TRANSMISSAO + 200;
    // digito 0 em gfedcba
    localparam logic [6:0] SEG_ZERO = 7'b0111111;

    logic                        clock;
    logic                        rst_n;
    logic                        iniciar;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [ENDERECO_LARGURA-1:0] paddr;
    logic [NUM_COLUNAS-1:0]      pwdata;
    logic [NUM_COLUNAS-1:0]      prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        saida_serial;
    logic                        fim;
    logic                        db_partida_serial;
    logic                        db_saida_serial;
    logic [6:0]                  db_estado;

    entrada_t               tabela [NUM_ENTRADAS];
    int                     num_entradas;
    int                     inicio;
    logic [NUM_COLUNAS-1:0] modelo [NUM_LINHAS];
    logic [15:0]            lfsr;
    int                     contagem_fim;
    int                     contagem_partida;
    int                     ciclos;

    gerador_clock #(.PERIODO(100)) u_gerador_clock (.clock(clock));

    transmissao_serial u_transmissao_serial (
        .clock             (clock),
        .rst_n             (rst_n),
        .iniciar           (iniciar),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .saida_serial      (saida_serial),
        .fim               (fim),
        .db_partida_serial (db_partida_serial),
        .db_saida_serial   (db_saida_serial),
        .db_estado         (db_estado)
    );

    task automatic abort_run(input string motivo);
        $display("%s", motivo);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string nome, input logic [NUM_COLUNAS-1:0] obtido,
                              input logic [NUM_COLUNAS-1:0] esperado);
        if (obtido !== esperado) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", nome, obtido, esperado));
        end
    endtask

    task automatic check_bit(input string nome, input logic obtido, input logic esperado);
        if (obtido !== esperado) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", nome, obtido, esperado));
        end
    endtask

    task automatic check_display(input string nome, input logic [6:0] obtido,
                                 input logic [6:0] esperado);
        if (obtido !== esperado) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", nome, obtido, esperado));
        end
    endtask

    // lfsr de fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] estado);
        return {estado[14:0], estado[15] ^ estado[13] ^ estado[12] ^ estado[10]};
    endfunction

    function automatic logic [NUM_COLUNAS-1:0] random_byte();
        logic [NUM_COLUNAS-1:0] valor;
        valor = '0;
        for (int i = 0; i < NUM_COLUNAS; i++) begin
            lfsr  = lfsr_step(lfsr);
            valor = {valor[NUM_COLUNAS-2:0], lfsr[0]};
        end
        return valor;
    endfunction

    function automatic void add_entry(input apb_op_t op, input int endereco, input int dado,
                                      input int esperado, input logic erro);
        tabela[num_entradas] = '{op, ENDERECO_LARGURA'(endereco), NUM_COLUNAS'(dado),
                                 NUM_COLUNAS'(esperado), erro};
        num_entradas++;
    endfunction

    // leituras do reset, escrita aleatoria, releitura e enderecos invalidos
    function automatic void build_first_board();
        for (int r = 0; r < NUM_LINHAS; r++) begin
            add_entry(leitura, 4 * r, 0, 0, 1'b0);
        end
        for (int r = 0; r < NUM_LINHAS; r++) begin
            modelo[r] = random_byte();
            add_entry(escrita, 4 * r, int'(modelo[r]), 0, 1'b0);
        end
        for (int r = 0; r < NUM_LINHAS; r++) begin
            add_entry(leitura, 4 * r, 0, int'(modelo[r]), 1'b0);
        end
        add_entry(escrita, 6, 8'hff, 0, 1'b1);
        add_entry(leitura, 6, 0, 0, 1'b1);
        add_entry(leitura, 31, 0, 0, 1'b1);
        // linha 1 nao pode ter mudado
        add_entry(leitura, 4, 0, int'(modelo[1]), 1'b0);
    endfunction

    function automatic void build_second_board();
        for (int r = 0; r < NUM_LINHAS; r++) begin
            modelo[r] = random_byte();
            add_entry(escrita, 4 * r, int'(modelo[r]), 0, 1'b0);
        end
        for (int r = 0; r < NUM_LINHAS; r++) begin
            add_entry(leitura, 4 * r, 0, int'(modelo[r]), 1'b0);
        end
    endfunction

    task automatic apb_transfer(input apb_op_t op, input logic [ENDERECO_LARGURA-1:0] endereco,
                                input logic [NUM_COLUNAS-1:0] dado,
                                output logic [NUM_COLUNAS-1:0] lido, output logic erro);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = (op == escrita);
        paddr   = endereco;
        pwdata  = dado;
        @(negedge clock);
        penable = 1'b1;
        @(posedge clock);
        while (pready !== 1'b1) begin
            @(posedge clock);
        end
        lido = prdata;
        erro = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apply_table(input int primeira, input int ultima);
        entrada_t               e;
        logic [NUM_COLUNAS-1:0] lido;
        logic                   erro;
        for (int i = primeira; i < ultima; i++) begin
            e = tabela[i];
            apb_transfer(e.op, e.endereco, e.dado, lido, erro);
            check_bit($sformatf("pslverr entry %0d", i), erro, e.erro);
            if (e.op == leitura) begin
                check_byte($sformatf("prdata entry %0d", i), lido, e.esperado);
            end
        end
    endtask

    // amostra no meio de cada bit a partir da descida da partida
    task automatic receive_frame(output logic [NUM_COLUNAS-1:0] dados,
                                 output logic bit_partida, output logic bit_parada);
        @(negedge clock);
        while (saida_serial !== 1'b0) begin
            @(negedge clock);
        end
        repeat (CICLOS_POR_BIT / 2 - 1) @(negedge clock);
        bit_partida = saida_serial;
        for (int i = 0; i < NUM_COLUNAS; i++) begin
            repeat (CICLOS_POR_BIT) @(negedge clock);
            dados[i] = saida_serial;
        end
        repeat (CICLOS_POR_BIT) @(negedge clock);
        bit_parada = saida_serial;
    endtask

    task automatic run_transmission(input logic com_pulsos);
        logic [NUM_COLUNAS-1:0] dados;
        logic                   b_partida;
        logic                   b_parada;
        @(negedge clock);
        contagem_fim     = 0;
        contagem_partida = 0;
        iniciar          = 1'b1;
        @(negedge clock);
        iniciar = 1'b0;
        fork
            for (int r = 0; r < NUM_LINHAS; r++) begin
                receive_frame(dados, b_partida, b_parada);
                check_bit($sformatf("row %0d start bit", r), b_partida, 1'b0);
                check_byte($sformatf("row %0d data", r), dados, modelo[r]);
                check_bit($sformatf("row %0d stop bit", r), b_parada, 1'b1);
            end
            if (com_pulsos) begin
                // pulsos de iniciar com a transmissao em curso
                repeat (30) @(negedge clock);
                iniciar = 1'b1;
                @(negedge clock);
                iniciar = 1'b0;
                repeat (120) @(negedge clock);
                iniciar = 1'b1;
                @(negedge clock);
                iniciar = 1'b0;
            end
        join
        if (contagem_fim != 0) begin
            abort_run("fim went high before the last stop bit");
        end
        while (fim !== 1'b1) begin
            @(negedge clock);
        end
        check_bit("saida_serial", saida_serial, 1'b1);
        @(negedge clock);
        check_bit("fim", fim, 1'b0);
        check_display("db_estado", db_estado, SEG_ZERO);
        // linha ociosa, nenhum quadro extra
        repeat (2 * CICLOS_QUADRO) begin
            @(negedge clock);
            check_bit("saida_serial", saida_serial, 1'b1);
        end
        if (contagem_fim != 1) begin
            abort_run($sformatf("fim was high for %0d cycles instead of one", contagem_fim));
        end
        if (contagem_partida != NUM_LINHAS) begin
            abort_run($sformatf("db_partida_serial pulsed %0d times instead of %0d",
                                contagem_partida, NUM_LINHAS));
        end
    endtask

    // monitor das saidas de pulso e depuracao
    initial begin
        forever begin
            @(negedge clock);
            if (rst_n) begin
                check_bit("db_saida_serial", db_saida_serial, saida_serial);
                if (fim) begin
                    contagem_fim++;
                end
                if (db_partida_serial) begin
                    contagem_partida++;
                end
            end
        end
    end

    initial begin
        ciclos = 0;
        while (ciclos < LIMITE) begin
            @(posedge clock);
            ciclos++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMITE);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        rst_n            = 1'b0;
        iniciar          = 1'b0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        lfsr             = 16'd38688;
        num_entradas     = 0;
        contagem_fim     = 0;
        contagem_partida = 0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_bit("saida_serial", saida_serial, 1'b1);
        check_bit("fim", fim, 1'b0);
        check_display("db_estado", db_estado, SEG_ZERO);

        build_first_board();
        apply_table(0, num_entradas);
        run_transmission(1'b0);

        // tabuleiro novo e iniciar repetido
        inicio = num_entradas;
        build_second_board();
        apply_table(inicio, num_entradas);
        run_transmission(1'b1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- transmissao_serial.f
verilog/transmissao_serial_pkg.sv
verilog/tabuleiro_pkg.sv
verilog/tabuleiro_apb.sv
verilog/transmissao_serial_fd.sv
verilog/transmissao_serial_uc.sv
verilog/hexa7seg.sv
verilog/transmissao_serial.sv
testbench/gerador_clock.sv
testbench/transmissao_serial_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module transmissao_serial_tb \
    -f transmissao_serial.f -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
